// ==== common/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  // Default data width for every module in the ALU
  localparam int DEFAULT_WIDTH = 32;

  // Operation code carried from the issue stage to the units
  typedef logic [2:0] op_t;

  // Condition flags packed as N Z C V, top to bottom
  typedef logic [3:0] flags_t;

  // Arithmetic ops, both served by the adder
  localparam op_t OP_ADD = 3'd0;
  localparam op_t OP_SUB = 3'd1;

  // Bitwise ops, served by the logic unit
  localparam op_t OP_AND = 3'd2;
  localparam op_t OP_OR  = 3'd3;
  localparam op_t OP_XOR = 3'd4;

  // Shifts, served by the barrel shifter
  localparam op_t OP_SLL = 3'd5;
  localparam op_t OP_SRL = 3'd6;
  localparam op_t OP_SRA = 3'd7;

  // Bit positions inside flags_t
  // Overflow, signed result out of range
  localparam int FLAG_V = 0;
  // Carry out, or no borrow on subtract
  localparam int FLAG_C = 1;
  // Result is all zeros
  localparam int FLAG_Z = 2;
  // Top bit of the result
  localparam int FLAG_N = 3;

endpackage

`default_nettype wire

// ==== common/operand_if.sv ====
`default_nettype none

// Operands issued by control, read by the combinational units
interface operand_if #(
  parameter int data_width = alu_pkg::DEFAULT_WIDTH
);
  import alu_pkg::*;

  // First operand, straight from the issue register
  logic [data_width-1:0] a;
  // Second operand, inverted for subtract
  logic [data_width-1:0] b;
  // Issued opcode
  op_t                   op;
  // Adder carry in, set for subtract
  logic                  c_in;

  // Control side drives everything
  modport ctrl (output a, b, op, c_in);

  // Units only read
  modport unit (input a, b, op, c_in);

endinterface

`default_nettype wire

// ==== adder/cla_4.sv ====
`default_nettype none

// 4-bit carry-lookahead block
module cla_4 (
  input  logic       c_in,
  input  logic [3:0] a,
  input  logic [3:0] b,
  output logic [3:0] s,
  output logic       c_out,
  output logic       c3
);

  // Per-bit propagate and generate
  logic [3:0] p;
  logic [3:0] g;

  // Carries into bits 1 and 2
  logic       c1;
  logic       c2;

  // Pi = Ai ^ Bi
  assign p = a ^ b;
  // Gi = Ai & Bi
  assign g = a & b;

  // Every carry is a flat sum of products of the block inputs
  // Nothing ripples from one bit to the next

  // C1 = G0 + P0.C0
  assign c1 = g[0]
            | (p[0] & c_in);

  // C2 = G1 + P1.G0 + P1.P0.C0
  assign c2 = g[1]
            | (p[1] & g[0])
            | (p[1] & p[0] & c_in);

  // C3 = G2 + P2.G1 + P2.P1.G0 + P2.P1.P0.C0
  // Also exported, the adder needs it for signed overflow
  assign c3 = g[2]
            | (p[2] & g[1])
            | (p[2] & p[1] & g[0])
            | (p[2] & p[1] & p[0] & c_in);

  // C4 = G3 + P3.G2 + P3.P2.G1 + P3.P2.P1.G0 + P3.P2.P1.P0.C0
  assign c_out = g[3]
               | (p[3] & g[2])
               | (p[3] & p[2] & g[1])
               | (p[3] & p[2] & p[1] & g[0])
               | (p[3] & p[2] & p[1] & p[0] & c_in);

  // Si = Pi ^ Ci
  assign s = p ^ {c3, c2, c1, c_in};

endmodule

`default_nettype wire

// ==== adder/cla_adder.sv ====
`default_nettype none

// Parameter-width adder built from a chain of 4-bit lookahead blocks
module cla_adder #(
  parameter int data_width = alu_pkg::DEFAULT_WIDTH
) (
  operand_if.unit              ops,
  output logic [data_width-1:0] sum,
  output logic                  c_out,
  output logic                  overflow
);

  // Number of 4-bit blocks
  localparam int num_blocks = data_width / 4;

  // Carry between blocks, entry 0 is the adder carry in
  logic [num_blocks:0]   blk_carry;
  // Carry into the top bit of each block
  logic [num_blocks-1:0] blk_c3;

  assign blk_carry[0] = ops.c_in;

  // One lookahead block per nibble
  for (genvar i = 0; i < num_blocks; i++) begin : g_blk
    // Top bit of this nibble
    localparam int hi = 4 * i + 3;

    cla_4 u_cla_4 (
      .c_in  (blk_carry[i]),
      .a     (ops.a[hi -: 4]),
      .b     (ops.b[hi -: 4]),
      .s     (sum[hi -: 4]),
      .c_out (blk_carry[i+1]),
      .c3    (blk_c3[i])
    );
  end

  // Unsigned carry out of the whole word
  assign c_out = blk_carry[num_blocks];

  // Signed overflow, carry into MSB differs from carry out of MSB
  // Both come from the last block
  assign overflow = blk_c3[num_blocks-1] ^ blk_carry[num_blocks];

endmodule

`default_nettype wire

// ==== rtl/logic_unit.sv ====
`default_nettype none

// Bitwise and, or, xor
module logic_unit #(
  parameter int data_width = alu_pkg::DEFAULT_WIDTH
) (
  operand_if.unit               ops,
  output logic [data_width-1:0] logic_result
);

  import alu_pkg::*;

  always_comb begin
    case (ops.op)
      OP_AND: begin
        logic_result = ops.a & ops.b;
      end
      OP_OR: begin
        logic_result = ops.a | ops.b;
      end
      OP_XOR: begin
        logic_result = ops.a ^ ops.b;
      end
      default: begin
        // Held at zero for non-logic ops, keeps the path quiet
        logic_result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/shifter.sv ====
`default_nettype none

// Logarithmic barrel shifter, one stage per bit of the shift amount
module shifter #(
  parameter int data_width = alu_pkg::DEFAULT_WIDTH
) (
  operand_if.unit               ops,
  output logic [data_width-1:0] shift_result
);

  import alu_pkg::*;

  // Shift amount width, low bits of b only
  localparam int shamt_w = $clog2(data_width);

  // Word after each stage, stage 0 is the input
  logic [data_width-1:0] stage [0:shamt_w];
  // Left shift runs through the right-shift stages bit-reversed
  logic                  left;
  // Bit shifted in from the top
  logic                  fill;

  // Mirror a word end to end
  function automatic logic [data_width-1:0] reverse(input logic [data_width-1:0] d);
    logic [data_width-1:0] r;
    for (int i = 0; i < data_width; i++) begin
      r[i] = d[data_width-1-i];
    end
    return r;
  endfunction

  assign left = (ops.op == OP_SLL);

  // Sign fill for arithmetic right, zeros otherwise
  assign fill = (ops.op == OP_SRA) ? ops.a[data_width-1] : 1'b0;

  assign stage[0] = left ? reverse(ops.a) : ops.a;

  // Stage i shifts right by 2**i when bit i of b is set
  for (genvar i = 0; i < shamt_w; i++) begin : g_stage
    localparam int step = 1 << i;

    assign stage[i+1] = ops.b[i] ? {{step{fill}}, stage[i][data_width-1:step]}
                                 : stage[i];
  end

  // Undo the reversal for left shifts
  assign shift_result = left ? reverse(stage[shamt_w]) : stage[shamt_w];

endmodule

`default_nettype wire

// ==== rtl/alu_control.sv ====
`default_nettype none

// Issue stage, operand prep, result select, flags and done
module alu_control #(
  parameter int data_width = alu_pkg::DEFAULT_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  alu_pkg::op_t          op,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  operand_if.ctrl               ops,
  input  logic [data_width-1:0] sum,
  input  logic [data_width-1:0] logic_result,
  input  logic [data_width-1:0] shift_result,
  input  logic                  c_out,
  input  logic                  overflow,
  output logic [data_width-1:0] result,
  output alu_pkg::flags_t       flags,
  output logic                  done
);

  import alu_pkg::*;

  // Issue register
  op_t                   iss_op;
  logic [data_width-1:0] iss_a;
  logic [data_width-1:0] iss_b;
  logic                  iss_valid;

  // Decode of the issued op
  logic                  is_sub;
  logic                  is_arith;

  // Selected result and its flags, registered next edge
  logic [data_width-1:0] sel_result;
  flags_t                sel_flags;

  assign is_sub   = (iss_op == OP_SUB);
  assign is_arith = (iss_op == OP_ADD) || is_sub;

  // Operands into the units
  // Subtract is a + ~b + 1, so the adder never needs to know
  assign ops.a    = iss_a;
  assign ops.op   = iss_op;
  assign ops.b    = is_sub ? ~iss_b : iss_b;
  assign ops.c_in = is_sub;

  // Pick the unit that matches the issued op
  always_comb begin
    case (iss_op)
      OP_ADD, OP_SUB: begin
        sel_result = sum;
      end
      OP_AND, OP_OR, OP_XOR: begin
        sel_result = logic_result;
      end
      default: begin
        // SLL, SRL, SRA
        sel_result = shift_result;
      end
    endcase
  end

  // Flags from the selected result
  always_comb begin
    sel_flags         = '0;
    sel_flags[FLAG_Z] = (sel_result == '0);
    sel_flags[FLAG_N] = sel_result[data_width-1];
    // C and V only mean something for add and sub
    sel_flags[FLAG_C] = is_arith & c_out;
    sel_flags[FLAG_V] = is_arith & overflow;
  end

  // Issue payload, loaded on start only
  always_ff @(posedge clk) begin
    if (start) begin
      iss_op <= op;
      iss_a  <= a;
      iss_b  <= b;
    end
  end

  // Issue valid, one cycle per start
  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= start;
    end
  end

  // Result stage, second edge after start
  // result and flags hold while nothing is in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      flags  <= '0;
      done   <= 1'b0;
    end else begin
      done <= iss_valid;
      if (iss_valid) begin
        result <= sel_result;
        flags  <= sel_flags;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/alu_top.sv ====
`default_nettype none

// Registered integer ALU, top level
module alu_top #(
  parameter int data_width = alu_pkg::DEFAULT_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  alu_pkg::op_t          op,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  output logic [data_width-1:0] result,
  output alu_pkg::flags_t       flags,
  output logic                  done
);

  // Unit outputs back into control
  logic [data_width-1:0] sum;
  logic [data_width-1:0] logic_result;
  logic [data_width-1:0] shift_result;
  logic                  c_out;
  logic                  overflow;

  // Issued operands, shared by all three units
  operand_if #(.data_width(data_width)) ops_bus ();

  alu_control #(.data_width(data_width)) u_control (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .op           (op),
    .a            (a),
    .b            (b),
    .ops          (ops_bus.ctrl),
    .sum          (sum),
    .logic_result (logic_result),
    .shift_result (shift_result),
    .c_out        (c_out),
    .overflow     (overflow),
    .result       (result),
    .flags        (flags),
    .done         (done)
  );

  // Add and subtract
  cla_adder #(.data_width(data_width)) u_adder (
    .ops      (ops_bus.unit),
    .sum      (sum),
    .c_out    (c_out),
    .overflow (overflow)
  );

  // And, or, xor
  logic_unit #(.data_width(data_width)) u_logic (
    .ops          (ops_bus.unit),
    .logic_result (logic_result)
  );

  // Shift amount is the low bits of b
  shifter #(.data_width(data_width)) u_shifter (
    .ops          (ops_bus.unit),
    .shift_result (shift_result)
  );

endmodule

`default_nettype wire

// ==== testbench/alu_tb.sv ====
`default_nettype none

// Testbench for the registered ALU, vectors from the data file plus random add and xor
module alu_tb;

  import alu_pkg::*;

  localparam int width = 32;
  // Cycles allowed for outstanding results to drain
  localparam int done_timeout = 10;

  logic               clk;
  logic               rst;
  logic               start;
  op_t                op;
  logic [width-1:0]   a;
  logic [width-1:0]   b;
  logic [width-1:0]   result;
  flags_t             flags;
  logic               done;

  // Directed vectors read from the data file
  op_t                vec_op[$];
  logic [width-1:0]   vec_a[$];
  logic [width-1:0]   vec_b[$];
  logic [width-1:0]   vec_result[$];
  flags_t             vec_flags[$];

  // Expected results of issued ops, in issue order
  logic [width-1:0]   exp_result_q[$];
  flags_t             exp_flags_q[$];

  // Last completed result, must hold while done is low
  logic [width-1:0]   last_result;
  flags_t             last_flags;

  // Start as seen by the DUT on the last two edges
  logic [1:0]         start_hist;
  logic               monitor_on;

  alu_top #(.data_width(width)) uut (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .op     (op),
    .a      (a),
    .b      (b),
    .result (result),
    .flags  (flags),
    .done   (done)
  );

  always #10 clk = ~clk;

  task automatic end_with_failure();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input logic [width-1:0] exp,
                              input logic [width-1:0] act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_flags(input flags_t exp, input flags_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: flags expected %b actual %b", $time, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_done(input bit exp, input bit act);
    if (act !== exp) begin
      $display("mismatch at %0t: done expected %b actual %b", $time, exp, act);
      end_with_failure();
    end
  endtask

  // Reference for random ops, straight from the flag rules
  task automatic compute_expected(input op_t rop, input logic [width-1:0] x,
                                  input logic [width-1:0] y,
                                  output logic [width-1:0] r, output flags_t f);
    logic [width:0] wide;
    f = '0;
    if (rop == OP_ADD) begin
      wide      = {1'b0, x} + {1'b0, y};
      r         = wide[width-1:0];
      f[FLAG_C] = wide[width];
      // Same-sign operands giving a result of the other sign
      f[FLAG_V] = (x[width-1] == y[width-1]) && (r[width-1] != x[width-1]);
    end else begin
      r = x ^ y;
    end
    f[FLAG_Z] = (r == '0);
    f[FLAG_N] = r[width-1];
  endtask

  task automatic load_vectors();
    int               fd;
    int               n;
    string            line;
    op_t              v_op;
    logic [width-1:0] v_a;
    logic [width-1:0] v_b;
    logic [width-1:0] v_r;
    flags_t           v_f;
    fd = $fopen("testbench/alu_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      end_with_failure();
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Skip blank lines and the column header
      if (n == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h", v_op, v_a, v_b, v_r, v_f);
      if (n != 5) begin
        $display("test data line could not be parsed: %s", line);
        end_with_failure();
      end
      vec_op.push_back(v_op);
      vec_a.push_back(v_a);
      vec_b.push_back(v_b);
      vec_result.push_back(v_r);
      vec_flags.push_back(v_f);
    end
    $fclose(fd);
    if (vec_op.size() == 0) begin
      $display("test data file holds no vectors");
      end_with_failure();
    end
  endtask

  // One start per call, start stays high for back-to-back issue
  task automatic issue_op(input op_t iop, input logic [width-1:0] x,
                          input logic [width-1:0] y,
                          input logic [width-1:0] exp_r, input flags_t exp_f);
    @(posedge clk);
    start <= 1'b1;
    op    <= iop;
    a     <= x;
    b     <= y;
    exp_result_q.push_back(exp_r);
    exp_flags_q.push_back(exp_f);
  endtask

  task automatic end_issue();
    @(posedge clk);
    start <= 1'b0;
  endtask

  // Wait until every issued op has completed
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (exp_result_q.size() != 0) begin
      if (cycles == done_timeout) begin
        $display("done never arrived");
        end_with_failure();
      end
      @(posedge clk);
      cycles++;
    end
  endtask

  // Done timing follows start two edges later
  always @(posedge clk) begin
    start_hist <= rst ? 2'b00 : {start_hist[0], start};
  end

  // Done timing, in-order results and hold between ops
  always @(negedge clk) begin : done_monitor
    logic [width-1:0] exp_r;
    flags_t           exp_f;
    if (monitor_on) begin
      check_done(start_hist[1], done);
      if (done) begin
        if (exp_result_q.size() == 0) begin
          $display("done came with no operation in flight");
          end_with_failure();
        end
        exp_r = exp_result_q.pop_front();
        exp_f = exp_flags_q.pop_front();
        check_result("result", exp_r, result);
        check_flags(exp_f, flags);
        last_result = result;
        last_flags  = flags;
      end else begin
        check_result("result", last_result, result);
        check_flags(last_flags, flags);
      end
    end
  end

  initial begin : main
    op_t              rop;
    logic [width-1:0] x;
    logic [width-1:0] y;
    logic [width-1:0] r;
    flags_t           f;
    void'($urandom(32'h3b28));
    clk         = 1'b0;
    rst         = 1'b1;
    start       = 1'b0;
    op          = OP_ADD;
    a           = '0;
    b           = '0;
    start_hist  = 2'b00;
    monitor_on  = 1'b0;
    last_result = '0;
    last_flags  = '0;
    load_vectors();

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Registers cleared by reset
    @(negedge clk);
    check_done(1'b0, done);
    check_result("result", '0, result);
    check_flags('0, flags);
    @(posedge clk);
    monitor_on <= 1'b1;

    // Directed vectors, one op at a time
    for (int i = 0; i < vec_op.size(); i++) begin
      issue_op(vec_op[i], vec_a[i], vec_b[i], vec_result[i], vec_flags[i]);
      end_issue();
      wait_idle();
      // Idle cycles, result and flags must hold
      repeat (2) @(posedge clk);
    end

    // Same vectors back to back, two ops in flight
    for (int i = 0; i < vec_op.size(); i++) begin
      issue_op(vec_op[i], vec_a[i], vec_b[i], vec_result[i], vec_flags[i]);
    end
    end_issue();
    wait_idle();

    // Random add and xor, back to back
    for (int i = 0; i < 40; i++) begin
      x   = $urandom();
      y   = $urandom();
      rop = (i % 2 == 0) ? OP_ADD : OP_XOR;
      compute_expected(rop, x, y, r, f);
      issue_op(rop, x, y, r, f);
    end
    end_issue();
    wait_idle();
    repeat (3) @(posedge clk);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/alu_testdata.txt ====
# columns: opcode a b expected_result expected_flags, all hex
# opcodes 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra, flags bits N Z C V
0 7fffffff 00000001 80000000 9
0 ffffffff 00000001 00000000 6
1 00000000 00000001 ffffffff 8
0 00000005 00000003 00000008 0
1 00000005 00000005 00000000 6
1 80000000 00000001 7fffffff 3
0 80000000 80000000 00000000 7
1 00000003 00000005 fffffffe 8
0 12345678 11111111 23456789 0
2 ff00ff00 0f0f0f0f 0f000f00 0
2 aaaaaaaa 55555555 00000000 4
3 80000000 00000001 80000001 8
4 ffffffff ffffffff 00000000 4
4 ffff0000 0000ffff ffffffff 8
5 12345678 00000000 12345678 0
5 12345678 00000001 2468acf0 0
5 00000001 0000001f 80000000 8
5 00000003 ffffffe1 00000006 0
6 80000000 0000001f 00000001 0
6 f0000000 00000004 0f000000 0
6 00000001 00000001 00000000 4
7 80000000 0000001f ffffffff 8
7 f0000000 00000004 ff000000 8
7 70000000 00000024 07000000 0
7 87654321 00000000 87654321 8
6 87654321 fffffe20 87654321 8

// ==== sim.f ====
common/alu_pkg.sv
common/operand_if.sv
adder/cla_4.sv
adder/cla_adder.sv
rtl/logic_unit.sv
rtl/shifter.sv
rtl/alu_control.sv
rtl/alu_top.sv
testbench/alu_tb.sv

// ==== Bender.yml ====
package:
  name: alu

sources:
  - common/alu_pkg.sv
  - common/operand_if.sv
  - adder/cla_4.sv
  - adder/cla_adder.sv
  - rtl/logic_unit.sv
  - rtl/shifter.sv
  - rtl/alu_control.sv
  - rtl/alu_top.sv
  - target: test
    files:
      - testbench/alu_tb.sv
